// File: rtl/exe_cu_pkg.sv
// Execute control unit package with control word, unit op types and FSM encodings
`default_nettype none

package exe_cu_pkg;

	// Result select width, top bit kept for a CSR path
	localparam int unsigned RES_SEL_W = 7;

	// Shift unit operating mode
	typedef enum logic [1:0] {
		SHIFT_NONE      = 2'b00,
		SHIFT_LEFT      = 2'b01,
		SHIFT_RIGHT     = 2'b10,
		SHIFT_ROT_RIGHT = 2'b11
	} shift_mode_e;

	// Encoded shift amount from operand B
	// {|opb[4:1], opb[0]}, anything from 2 up takes several cycles
	typedef enum logic [1:0] {
		SIZE_ZERO      = 2'b00,
		SIZE_ONE       = 2'b01,
		SIZE_MULTI     = 2'b10,
		SIZE_MULTI_ALT = 2'b11
	} shift_size_e;

	typedef enum logic {
		MEM_LOAD  = 1'b0,
		MEM_STORE = 1'b1
	} mem_op_e;

	// Transfer size on the data bus
	typedef enum logic [1:0] {
		MEM_BYTE = 2'b00,
		MEM_HALF = 2'b01,
		MEM_WORD = 2'b10
	} mem_size_e;

	// Multi-cycle sequencer states
	typedef enum logic [2:0] {
		MC_IDLE = 3'd0, // Waiting for a launch
		MC_REQ  = 3'd1, // en high, waiting for busy
		MC_RUN  = 3'd2, // Unit working
		MC_WB   = 3'd3, // Result settles into the write-back mux
		MC_DONE = 3'd4  // One-cycle completion point
	} mc_state_e;

	// Decoded control word from the decode stage
	typedef struct packed {
		logic        alu_unsigned_n; // Signed compare when low
		logic        alu_add;
		logic        alu_sub;
		logic        alu_logic;
		logic [1:0]  cond_sel;       // Branch condition
		logic        cond_neg;       // Invert branch condition
		logic        bju_en;
		logic        jump;           // JAL / JALR
		shift_mode_e shift_mode;
		logic        mem_en;
		mem_op_e     mem_op;
		mem_size_e   mem_size;
		logic        slt_en;
		logic        add_pc_en;      // AUIPC
		logic        reg_wr_en;      // Instruction writes rd
	} exe_ctrl_word_t;

	typedef struct packed {
		logic unsigned_n;
		logic add;
		logic sub;
		logic logic_op;
	} alu_op_t;

	typedef struct packed {
		logic [1:0] cond_sel;
		logic       cond_neg;
		logic       jump;
		logic       bju_en;
	} bju_op_t;

	// Result mux select, MSB first
	typedef struct packed {
		logic        csr;        // No CSR port, tied low
		logic        load;
		logic        auipc;
		logic        slt;
		shift_size_e shift_size; // Fast shift result for sizes 0 and 1
		logic        jump_link;  // Return address for jumps
	} res_sel_t;

endpackage

`default_nettype wire

// File: rtl/mc_ctrl_if.sv
// Control link between decoder, one multi-cycle sequencer and the event controller
`timescale 1ns/1ps
`default_nettype none

interface mc_ctrl_if;

	logic need;     // Current instruction uses this unit
	logic launch;   // Fresh instruction present, not yet served by this unit
	logic abort;    // Exception taken, nothing may start
	logic complete; // Sequencer in MC_DONE, one cycle

	// Decoder side
	modport dec (
		output need
	);

	// Sequencer side
	modport seq (
		input  need,
		input  launch,
		input  abort,
		output complete
	);

	// Event controller side
	modport ctrl (
		output launch,
		output abort,
		input  need,
		input  complete
	);

endinterface

`default_nettype wire

// File: rtl/exe_cu_decode.sv
// Execute control decoder, fans the control word out to unit ops, selects and MC requests
`timescale 1ns/1ps
`default_nettype none

module exe_cu_decode (
	input  exe_cu_pkg::exe_ctrl_word_t ctrl_word_i,
	input  exe_cu_pkg::shift_size_e    shu_size_i,
	input  logic                       btaken_i,

	output exe_cu_pkg::alu_op_t        alu_op_o,
	output exe_cu_pkg::bju_op_t        bju_op_o,
	output exe_cu_pkg::shift_mode_e    shu_mode_o,
	output exe_cu_pkg::mem_op_e        lsu_op_o,
	output exe_cu_pkg::mem_size_e      lsu_size_o,
	output exe_cu_pkg::res_sel_t       res_sel_o,
	output logic                       nextpc_sel_o,
	output logic                       reg_wr_req_o,

	mc_ctrl_if.dec                     shu_mc,
	mc_ctrl_if.dec                     lsu_mc
);

	import exe_cu_pkg::*;

	logic                 is_load;
	logic                 shift_multi;
	logic [RES_SEL_W-1:0] res_sel_vec;

	// ALU op straight from the flags
	always_comb begin
		alu_op_o.unsigned_n = ctrl_word_i.alu_unsigned_n;
		alu_op_o.add        = ctrl_word_i.alu_add;
		alu_op_o.sub        = ctrl_word_i.alu_sub;
		alu_op_o.logic_op   = ctrl_word_i.alu_logic;
	end

	// Branch/jump unit op
	always_comb begin
		bju_op_o.cond_sel = ctrl_word_i.cond_sel;
		bju_op_o.cond_neg = ctrl_word_i.cond_neg;
		bju_op_o.jump     = ctrl_word_i.jump;
		bju_op_o.bju_en   = ctrl_word_i.bju_en;
	end

	assign shu_mode_o = ctrl_word_i.shift_mode;
	assign lsu_op_o   = ctrl_word_i.mem_op;   // Load or store
	assign lsu_size_o = ctrl_word_i.mem_size; // Byte, half, word

	assign is_load = ctrl_word_i.mem_en & (ctrl_word_i.mem_op == MEM_LOAD);

	// Result mux select
	always_comb begin
		res_sel_vec = {
			1'b0,                  // CSR slot unused
			is_load,               // Load data
			ctrl_word_i.add_pc_en, // AUIPC
			ctrl_word_i.slt_en,    // SLT / SLTU
			shu_size_i,            // Shift size for fast result
			ctrl_word_i.jump       // Link address
		};
	end

	assign res_sel_o = res_sel_t'(res_sel_vec);

	// Jump, or taken branch
	assign nextpc_sel_o = ctrl_word_i.jump |
		(~ctrl_word_i.jump & ctrl_word_i.bju_en & btaken_i);

	assign reg_wr_req_o = ctrl_word_i.reg_wr_en;

	// Sizes 0 and 1 come from the fast path
	assign shift_multi = (shu_size_i == SIZE_MULTI) | (shu_size_i == SIZE_MULTI_ALT);

	// Multi-cycle requests
	assign shu_mc.need = (ctrl_word_i.shift_mode != SHIFT_NONE) & shift_multi;
	assign lsu_mc.need = ctrl_word_i.mem_en; // Every memory access waits on the LSU

endmodule

`default_nettype wire

// File: rtl/exe_mc_sequencer.sv
// Multi-cycle unit sequencer, four-phase en/busy handshake plus write-back and done steps
`timescale 1ns/1ps
`default_nettype none

module exe_mc_sequencer (
	input  logic   clk_i,
	input  logic   rstn_i,

	mc_ctrl_if.seq mc,

	input  logic   busy_i, // Unit busy
	output logic   en_o    // Unit enable
);

	import exe_cu_pkg::*;

	mc_state_e state_q;
	mc_state_e state_d;
	logic      en_d;
	logic      start;

	// Only a fresh, needed, non-faulting instruction starts the unit
	assign start = mc.need & mc.launch & ~mc.abort;

	// Next state and enable
	always_comb begin
		state_d = state_q;
		en_d    = en_o;
		case (state_q)
			MC_IDLE: begin
				if (start) begin
					state_d = MC_REQ;
					en_d    = 1'b1; // Phase 1
				end
			end
			MC_REQ: begin
				// Phase 2 seen, drop en for phase 3
				if (busy_i) begin
					state_d = MC_RUN;
					en_d    = 1'b0;
				end
			end
			MC_RUN: begin
				if (!busy_i) begin
					state_d = MC_WB; // Phase 4, unit finished
				end
			end
			MC_WB: begin
				state_d = MC_DONE;
			end
			MC_DONE: begin
				state_d = MC_IDLE;
			end
			default: begin
				state_d = MC_IDLE;
				en_d    = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rstn_i) begin
			state_q <= MC_IDLE;
			en_o    <= 1'b0;
		end else begin
			state_q <= state_d;
			en_o    <= en_d;
		end
	end

	// Single-cycle completion strobe
	assign mc.complete = (state_q == MC_DONE);

endmodule

`default_nettype wire

// File: rtl/exe_event_ctrl.sv
// Execute event controller, launch and exception tracking, write enable and stage busy
`timescale 1ns/1ps
`default_nettype none

module exe_event_ctrl (
	input  logic    clk_i,
	input  logic    rstn_i,
	input  logic    new_instr_i,
	input  logic    exc_i,        // Exception detected
	input  logic    reg_wr_req_i, // Instruction wants an rd write

	mc_ctrl_if.ctrl shu_mc,
	mc_ctrl_if.ctrl lsu_mc,

	output logic    trap_taken_o,
	output logic    reg_wr_en_o,
	output logic    exe_busy_o
);

	logic launch_q;   // Instruction in flight
	logic trap_q;     // Exception held until the next instruction
	logic shu_done_q; // Shift unit already finished this instruction
	logic lsu_done_q; // LSU already finished this instruction
	logic shu_fin;
	logic lsu_fin;
	logic busy;
	logic instr_end;

	// Live exception, or the held one while no new instruction arrives
	assign trap_taken_o = exc_i | (trap_q & ~new_instr_i);

	assign shu_fin = shu_done_q | shu_mc.complete;
	assign lsu_fin = lsu_done_q | lsu_mc.complete;

	// Busy until every needed unit reaches MC_DONE, never under a trap
	assign busy = launch_q & ~trap_taken_o &
		((shu_mc.need & ~shu_fin) | (lsu_mc.need & ~lsu_fin));
	assign exe_busy_o = busy;

	// Launch cycle for single-cycle ops, last MC_DONE for multi-cycle ones
	assign instr_end = launch_q & ~busy;

	// Exactly one write, blocked by an exception
	assign reg_wr_en_o = reg_wr_req_i & instr_end & ~trap_taken_o;

	// A unit that already completed must not restart
	assign shu_mc.launch = launch_q & ~shu_done_q;
	assign lsu_mc.launch = launch_q & ~lsu_done_q;
	assign shu_mc.abort  = trap_taken_o;
	assign lsu_mc.abort  = trap_taken_o;

	always_ff @(posedge clk_i) begin
		if (!rstn_i) begin
			launch_q   <= 1'b0;
			trap_q     <= 1'b0;
			shu_done_q <= 1'b0;
			lsu_done_q <= 1'b0;
		end else begin
			if (new_instr_i)
				launch_q <= 1'b1;
			else if (instr_end)
				launch_q <= 1'b0; // Retired

			if (new_instr_i)
				trap_q <= exc_i; // New instruction restarts the trap window
			else if (exc_i)
				trap_q <= 1'b1;

			if (new_instr_i || instr_end)
				shu_done_q <= 1'b0;
			else if (shu_mc.complete)
				shu_done_q <= 1'b1;

			if (new_instr_i || instr_end)
				lsu_done_q <= 1'b0;
			else if (lsu_mc.complete)
				lsu_done_q <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/exe_cu_top.sv
// Execute stage control unit top, decoder plus shift/LSU sequencers and event controller
`timescale 1ns/1ps
`default_nettype none

module exe_cu_top (
	input  logic                       clk_i,
	input  logic                       rstn_i,

	// Decode stage
	input  exe_cu_pkg::exe_ctrl_word_t ctrl_word_i,
	input  logic                       new_instr_i, // One pulse per instruction

	// ALU
	output exe_cu_pkg::alu_op_t        alu_op_o,

	// Shift unit
	input  exe_cu_pkg::shift_size_e    shu_size_i,
	input  logic                       shu_busy_i,
	output exe_cu_pkg::shift_mode_e    shu_mode_o,
	output logic                       shu_en_o,

	// Branch/jump unit
	output exe_cu_pkg::bju_op_t        bju_op_o,
	input  logic                       btaken_i,

	// Load/store unit
	input  logic                       lsu_busy_i,
	output exe_cu_pkg::mem_op_e        lsu_op_o,
	output exe_cu_pkg::mem_size_e      lsu_size_o,
	output logic                       lsu_en_o,

	// Exceptions
	input  logic                       exc_i,
	output logic                       trap_nextpc_sel_o,
	output logic                       trap_taken_o,

	// Datapath muxes
	output exe_cu_pkg::res_sel_t       res_sel_o,
	output logic                       nextpc_sel_o,

	// Pipeline sync
	output logic                       reg_wr_en_o,
	output logic                       exe_busy_o
);

	logic reg_wr_req; // Write flag from the control word
	logic trap_taken;

	mc_ctrl_if shu_mc ();
	mc_ctrl_if lsu_mc ();

	// Control word fan-out
	exe_cu_decode i_decode (
		.ctrl_word_i  (ctrl_word_i),
		.shu_size_i   (shu_size_i),
		.btaken_i     (btaken_i),
		.alu_op_o     (alu_op_o),
		.bju_op_o     (bju_op_o),
		.shu_mode_o   (shu_mode_o),
		.lsu_op_o     (lsu_op_o),
		.lsu_size_o   (lsu_size_o),
		.res_sel_o    (res_sel_o),
		.nextpc_sel_o (nextpc_sel_o),
		.reg_wr_req_o (reg_wr_req),
		.shu_mc       (shu_mc.dec),
		.lsu_mc       (lsu_mc.dec)
	);

	// Shift unit handshake
	exe_mc_sequencer i_shu_seq (
		.clk_i  (clk_i),
		.rstn_i (rstn_i),
		.mc     (shu_mc.seq),
		.busy_i (shu_busy_i),
		.en_o   (shu_en_o)
	);

	// LSU handshake
	exe_mc_sequencer i_lsu_seq (
		.clk_i  (clk_i),
		.rstn_i (rstn_i),
		.mc     (lsu_mc.seq),
		.busy_i (lsu_busy_i),
		.en_o   (lsu_en_o)
	);

	// Launch, trap, write and busy
	exe_event_ctrl i_event (
		.clk_i        (clk_i),
		.rstn_i       (rstn_i),
		.new_instr_i  (new_instr_i),
		.exc_i        (exc_i),
		.reg_wr_req_i (reg_wr_req),
		.shu_mc       (shu_mc.ctrl),
		.lsu_mc       (lsu_mc.ctrl),
		.trap_taken_o (trap_taken),
		.reg_wr_en_o  (reg_wr_en_o),
		.exe_busy_o   (exe_busy_o)
	);

	assign trap_taken_o      = trap_taken;
	assign trap_nextpc_sel_o = trap_taken; // Redirect to the trap vector

endmodule

`default_nettype wire

// File: tb/exe_cu_tb.sv
// Execute control unit testbench, random instructions against behavioral shift and load/store units
`timescale 1ns/1ps
`default_nettype none

// Behavioral multi-cycle unit, four-phase en/busy responder
module unit_model (
	input  logic clk_i,
	input  logic en_i,
	input  int   resp_dly_i, // Cycles from en to busy
	input  int   hold_i,     // Minimum busy length
	output logic busy_o
);
	initial busy_o = 1'b0;

	always begin
		@(posedge clk_i);
		#2;
		if (en_i) begin
			repeat (resp_dly_i) @(posedge clk_i);
			#2 busy_o = 1'b1;
			repeat (hold_i) @(posedge clk_i);
			#2;
			while (en_i) begin // Busy never drops before en
				@(posedge clk_i);
				#2;
			end
			busy_o = 1'b0;
		end
	end
endmodule

module exe_cu_tb;
	import exe_cu_pkg::*;

	localparam int NUM_INSTR  = 200;
	localparam int RST_CYCLES = 8;
	localparam int MAX_CYCLES = NUM_INSTR * 20 + RST_CYCLES; // Worst instruction stays under 20

	// Expected decoder view of one instruction
	typedef struct packed {
		alu_op_t     alu;
		bju_op_t     bju;
		shift_mode_e mode;
		mem_op_e     mop;
		mem_size_e   msize;
		res_sel_t    sel;
		logic        nextpc;
		logic        shu_mc; // Shift unit sequenced
		logic        lsu_mc; // LSU sequenced
	} exp_t;

	logic           clk_i = 1'b0;
	logic           rstn_i, new_instr_i, btaken_i, exc_i, shu_busy_i, lsu_busy_i;
	exe_ctrl_word_t ctrl_word_i;
	shift_size_e    shu_size_i;
	alu_op_t        alu_op_o;
	bju_op_t        bju_op_o;
	shift_mode_e    shu_mode_o;
	mem_op_e        lsu_op_o;
	mem_size_e      lsu_size_o;
	res_sel_t       res_sel_o;
	logic           shu_en_o, lsu_en_o, nextpc_sel_o, trap_nextpc_sel_o;
	logic           trap_taken_o, reg_wr_en_o, exe_busy_o;

	logic [31:0] lfsr_q = 32'hcc3a03d1;
	int          shu_dly = 1, shu_hold = 1, lsu_dly = 1, lsu_hold = 1;
	int          err_cnt, check_cnt, cycle_cnt, cyc, wr_cnt, shu_rise, lsu_rise;
	logic        finish_req = 1'b0, checks_done = 1'b0, in_instr = 1'b0;
	logic        cur_exc = 1'b0, cur_wr = 1'b0, mc;
	logic        prev_shu_en, prev_lsu_en, prev_shu_busy, prev_lsu_busy, prev_exe_busy;
	exp_t        cur_exp, now_exp;

	always #10 clk_i = ~clk_i;

	exe_cu_top i_dut (.*);

	unit_model i_shu_model (.clk_i(clk_i), .en_i(shu_en_o), .resp_dly_i(shu_dly),
		.hold_i(shu_hold), .busy_o(shu_busy_i));
	unit_model i_lsu_model (.clk_i(clk_i), .en_i(lsu_en_o), .resp_dly_i(lsu_dly),
		.hold_i(lsu_hold), .busy_o(lsu_busy_i));

	// Galois LFSR, one step per bit
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	// Expected unit ops, selects and multi-cycle class
	function automatic exp_t ref_model(exe_ctrl_word_t cw, shift_size_e sz, logic bt);
		exp_t e;
		e.alu    = {cw.alu_unsigned_n, cw.alu_add, cw.alu_sub, cw.alu_logic};
		e.bju    = {cw.cond_sel, cw.cond_neg, cw.jump, cw.bju_en};
		e.mode   = cw.shift_mode;
		e.mop    = cw.mem_op;
		e.msize  = cw.mem_size;
		e.sel    = {1'b0, cw.mem_en && cw.mem_op == MEM_LOAD, cw.add_pc_en, cw.slt_en, sz, cw.jump};
		e.nextpc = cw.jump | (cw.bju_en & bt); // Jump or taken branch
		e.shu_mc = (cw.shift_mode != SHIFT_NONE) && (sz >= SIZE_MULTI);
		e.lsu_mc = cw.mem_en;
		return e;
	endfunction

	task automatic report(string what, logic [31:0] got, logic [31:0] exp);
		err_cnt++;
		$display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, exp);
	endtask

	task automatic check_alu(alu_op_t got, alu_op_t exp, string what);
		check_cnt++;
		if (got !== exp) report(what, 32'(got), 32'(exp));
	endtask

	task automatic check_bju(bju_op_t got, bju_op_t exp, string what);
		check_cnt++;
		if (got !== exp) report(what, 32'(got), 32'(exp));
	endtask

	task automatic check_sel(res_sel_t got, res_sel_t exp, string what);
		check_cnt++;
		if (got !== exp) report(what, 32'(got), 32'(exp));
	endtask

	task automatic check_mode(shift_mode_e got, shift_mode_e exp, string what);
		check_cnt++;
		if (got !== exp) report(what, 32'(got), 32'(exp));
	endtask

	task automatic check_mem_op(mem_op_e got, mem_op_e exp, string what);
		check_cnt++;
		if (got !== exp) report(what, 32'(got), 32'(exp));
	endtask

	task automatic check_mem_size(mem_size_e got, mem_size_e exp, string what);
		check_cnt++;
		if (got !== exp) report(what, 32'(got), 32'(exp));
	endtask

	task automatic check_bit(logic got, logic exp, string what);
		check_cnt++;
		if (got !== exp) report(what, 32'(got), 32'(exp));
	endtask

	task automatic check_count(int got, int exp, string what);
		check_cnt++;
		if (got != exp) report(what, got, exp);
	endtask

	// Four-phase order on one unit
	task automatic check_phase(string unit, logic en, logic busy, logic p_en, logic p_busy,
		logic need);
		if (en && !p_en)
			check_bit(busy, 1'b0, {unit, " busy at en rise"});
		if (!en && p_en)
			check_bit(p_busy, 1'b1, {unit, " busy seen before en fall"});
		if (en)
			check_bit(need, 1'b1, {unit, " en without a request"});
	endtask

	// One instruction, class picked at random
	task automatic issue_instr();
		exe_ctrl_word_t cw;
		shift_size_e    sz;
		logic [1:0]     kind;
		logic [31:0]    tmp;
		kind = 2'(rand_bits(2));
		tmp  = rand_bits($bits(exe_ctrl_word_t));
		cw   = tmp[$bits(exe_ctrl_word_t)-1:0];
		sz   = shift_size_e'(2'(rand_bits(2)));
		case (kind)
			2'd0: begin // Single cycle, shift size 0 or 1
				cw.mem_en = 1'b0;
				sz = shift_size_e'({1'b0, sz[0]});
			end
			2'd1: begin // Multi-cycle shift
				cw.mem_en = 1'b0;
				if (cw.shift_mode == SHIFT_NONE)
					cw.shift_mode = SHIFT_LEFT;
				sz = shift_size_e'({1'b1, sz[0]});
			end
			2'd2: begin
				cw.mem_en     = 1'b1;
				cw.shift_mode = SHIFT_NONE; // Any size stays off the shifter
			end
			default: ; // Exception, fields left random
		endcase
		shu_dly  = 1 + int'(rand_bits(2)) % 3;
		shu_hold = 1 + int'(rand_bits(3));
		lsu_dly  = 1 + int'(rand_bits(2)) % 3;
		lsu_hold = 1 + int'(rand_bits(3));
		repeat (int'(rand_bits(2))) @(posedge clk_i); // Idle gap
		@(posedge clk_i);
		#2;
		tmp         = rand_bits(1);
		ctrl_word_i = cw;
		shu_size_i  = sz;
		btaken_i    = tmp[0];
		exc_i       = (kind == 2'd3);
		new_instr_i = 1'b1;
		@(posedge clk_i);
		#2;
		new_instr_i = 1'b0;
		exc_i       = 1'b0; // Trap latch holds from here
		while (exe_busy_o) begin
			@(posedge clk_i);
			#2;
		end
	endtask

	// Compare process, mid-cycle sampling
	always @(negedge clk_i) begin
		if (!rstn_i) begin
			check_bit(shu_en_o, 1'b0, "shu_en_o in reset");
			check_bit(lsu_en_o, 1'b0, "lsu_en_o in reset");
			check_bit(reg_wr_en_o, 1'b0, "reg_wr_en_o in reset");
			check_bit(trap_taken_o, 1'b0, "trap_taken_o in reset");
		end else begin
			now_exp = ref_model(ctrl_word_i, shu_size_i, btaken_i);
			check_alu(alu_op_o, now_exp.alu, "alu_op_o");
			check_bju(bju_op_o, now_exp.bju, "bju_op_o");
			check_mode(shu_mode_o, now_exp.mode, "shu_mode_o");
			check_mem_op(lsu_op_o, now_exp.mop, "lsu_op_o");
			check_mem_size(lsu_size_o, now_exp.msize, "lsu_size_o");
			check_sel(res_sel_o, now_exp.sel, "res_sel_o");
			check_bit(nextpc_sel_o, now_exp.nextpc, "nextpc_sel_o");
			if (new_instr_i || finish_req) begin
				if (in_instr) begin // Close the previous instruction
					check_count(wr_cnt, (cur_wr && !cur_exc) ? 1 : 0, "register writes");
					check_count(shu_rise, (cur_exp.shu_mc && !cur_exc) ? 1 : 0, "shu_en_o launches");
					check_count(lsu_rise, (cur_exp.lsu_mc && !cur_exc) ? 1 : 0, "lsu_en_o launches");
				end
				in_instr    = new_instr_i;
				cyc         = 0;
				wr_cnt      = 0;
				shu_rise    = 0;
				lsu_rise    = 0;
				checks_done = finish_req;
			end else begin
				cyc++;
			end
			if (new_instr_i) begin
				cur_exp = now_exp;
				cur_exc = exc_i;
				cur_wr  = ctrl_word_i.reg_wr_en;
			end
			mc = in_instr && !cur_exc && (cur_exp.shu_mc || cur_exp.lsu_mc);
			check_bit(trap_taken_o, cur_exc, "trap_taken_o");
			check_bit(trap_nextpc_sel_o, cur_exc, "trap_nextpc_sel_o");
			if (!mc || cyc == 0)
				check_bit(exe_busy_o, 1'b0, "exe_busy_o outside a multi-cycle op");
			else if (cyc == 1)
				check_bit(exe_busy_o, 1'b1, "exe_busy_o in the launch cycle");
			else if (exe_busy_o)
				check_bit(prev_exe_busy, 1'b1, "exe_busy_o before a busy cycle"); // No re-rise
			if (mc && (shu_en_o || shu_busy_i || lsu_en_o || lsu_busy_i))
				check_bit(exe_busy_o, 1'b1, "exe_busy_o while a unit works");
			if (reg_wr_en_o) begin
				wr_cnt++;
				check_bit(exe_busy_o, 1'b0, "exe_busy_o at the write");
				if (mc) begin
					check_bit(prev_exe_busy, 1'b1, "exe_busy_o before the write");
					check_bit(shu_busy_i | lsu_busy_i, 1'b0, "unit busy at the write");
				end else begin
					check_bit(in_instr, 1'b1, "write outside an instruction");
					check_count(cyc, 1, "write cycle");
				end
			end
			if (shu_en_o && !prev_shu_en)
				shu_rise++;
			if (lsu_en_o && !prev_lsu_en)
				lsu_rise++;
			check_phase("shu_en_o", shu_en_o, shu_busy_i, prev_shu_en, prev_shu_busy,
				in_instr && !cur_exc && cur_exp.shu_mc);
			check_phase("lsu_en_o", lsu_en_o, lsu_busy_i, prev_lsu_en, prev_lsu_busy,
				in_instr && !cur_exc && cur_exp.lsu_mc);
		end
		prev_shu_en   = shu_en_o;
		prev_lsu_en   = lsu_en_o;
		prev_shu_busy = shu_busy_i;
		prev_lsu_busy = lsu_busy_i;
		prev_exe_busy = exe_busy_o;
	end

	// Run limit
	always @(posedge clk_i) begin
		cycle_cnt++;
		if (cycle_cnt > MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the stage never went idle", cycle_cnt);
			$display("Test FAILED");
			$finish;
		end
	end

	// Stimulus
	initial begin
		rstn_i      = 1'b0;
		ctrl_word_i = '0;
		shu_size_i  = SIZE_ZERO;
		new_instr_i = 1'b0;
		btaken_i    = 1'b0;
		exc_i       = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_i);
		#2 rstn_i = 1'b1;
		for (int n = 0; n < NUM_INSTR; n++)
			issue_instr();
		@(posedge clk_i);
		#2 finish_req = 1'b1; // Closes the last instruction
		while (!checks_done)
			@(posedge clk_i);
		$display("Instructions: %0d, checks: %0d, errors: %0d", NUM_INSTR, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
rtl/exe_cu_pkg.sv
rtl/mc_ctrl_if.sv
rtl/exe_cu_decode.sv
rtl/exe_mc_sequencer.sv
rtl/exe_event_ctrl.sv
rtl/exe_cu_top.sv
tb/exe_cu_tb.sv
